// File: tb.f
src/hdmi_out_pkg.sv
src/vid_timing_if.sv
src/hdmi_mode_fsm.sv
src/video_timing_gen.sv
src/color_bar_gen.sv
src/video_out_regs.sv
src/hdmi_out_top.sv
verification/tb_clk_gen.sv
verification/tb_hdmi_out_checks.sv
verification/tb_hdmi_out.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the HDMI output testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_hdmi_out \
  --Mdir "$BUILD_DIR" -o tb_hdmi_out
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_hdmi_out" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
exit 1

// File: verification/tb_hdmi_out.sv
////////////////////////////////////////
// HDMI output stage testbench
// Mode 0, change to mode 1 and back
////////////////////////////////////////

`timescale 1ns/100ps

module tb_hdmi_out;

  // About fifteen frames of mode 1, with margin
  localparam int TIMEOUT_CYC = 20000;

  logic HDMI_CLK_w;
  logic HDMI_nRST_pp_w;
  logic mode_req;
  hdmi_out_pkg::mode_t mode_sel;
  logic mode_ack;
  logic vsync;
  logic hsync;
  logic de;
  hdmi_out_pkg::pixel_t vd;
  int chk_errs;
  int cycle_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clk_o  (HDMI_CLK_w),
    .rst_n_o(HDMI_nRST_pp_w)
  );

  hdmi_out_top #(
    .COLOR_WIDTH_O(8)
  ) i_dut (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_pp_w(HDMI_nRST_pp_w),
    .mode_req_i    (mode_req),
    .mode_sel_i    (mode_sel),
    .mode_ack_o    (mode_ack),
    .vsync_o       (vsync),
    .hsync_o       (hsync),
    .de_o          (de),
    .vd_o          (vd)
  );

  tb_hdmi_out_checks i_checks (
    .clk_i     (HDMI_CLK_w),
    .rst_n_i   (HDMI_nRST_pp_w),
    .mode_req_i(mode_req),
    .mode_sel_i(mode_sel),
    .mode_ack_i(mode_ack),
    .vsync_i   (vsync),
    .hsync_i   (hsync),
    .de_i      (de),
    .vd_i      (vd),
    .err_cnt_o (chk_errs)
  );

  // Frames counted on vsync rising edges, read mid-cycle
  task automatic wait_frames(input int n);
    int seen;
    logic vs_prev;
    seen = 0;
    vs_prev = vsync;
    while (seen < n) begin
      @(negedge HDMI_CLK_w);
      if (vsync && !vs_prev)
        seen++;
      vs_prev = vsync;
    end
  endtask

  // Four-phase request, random gaps
  task automatic change_mode(input hdmi_out_pkg::mode_t m);
    int dly;
    @(posedge HDMI_CLK_w);
    mode_sel <= m;
    dly = int'($urandom % 16) + 1;
    repeat (dly) @(posedge HDMI_CLK_w);
    mode_req <= 1'b1;
    @(negedge HDMI_CLK_w);
    while (!mode_ack)
      @(negedge HDMI_CLK_w);
    dly = int'($urandom % 24) + 1;
    repeat (dly) @(posedge HDMI_CLK_w);
    mode_req <= 1'b0;
    @(negedge HDMI_CLK_w);
    while (mode_ack)
      @(negedge HDMI_CLK_w);
  endtask

  task automatic end_run(input int timeouts);
    $display("Errors: %0d assertion, %0d timeout", chk_errs, timeouts);
    if ((chk_errs == 0) && (timeouts == 0))
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  endtask

  initial begin
    void'($urandom(97239));
    mode_req <= 1'b0;
    mode_sel <= 1'b0;
    @(posedge HDMI_nRST_pp_w);
    // Blanked frame, then mode 0 running
    wait_frames(3);
    change_mode(1'b1);
    wait_frames(2);
    change_mode(1'b0);
    wait_frames(2);
    end_run(0);
  end

  // Watchdog
  initial begin
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge HDMI_CLK_w);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
    end_run(1);
  end

endmodule

// File: verification/tb_hdmi_out_checks.sv
////////////////////////////////////////
// Output bus checker
// Model counters follow the DUT pins,
// concurrent assertions check them
////////////////////////////////////////

`timescale 1ns/100ps

module tb_hdmi_out_checks (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mode_req_i,
  input  hdmi_out_pkg::mode_t  mode_sel_i,
  input  logic                 mode_ack_i,
  input  logic                 vsync_i,
  input  logic                 hsync_i,
  input  logic                 de_i,
  input  hdmi_out_pkg::pixel_t vd_i,
  output int                   err_cnt_o
);

  int err_cnt = 0;
  // Pin values of the previous cycle
  logic hs_q, vs_q, de_q, req_q, ack_q;
  // Run lengths and cycles since the last edge
  int h_per, hs_len, vs_len, de_len, de_idle;
  int hs_cnt, burst_cnt;
  logic seen_de, chg_win;
  // Mode on the pins and the requested one
  hdmi_out_pkg::mode_t mode_m, mode_new;
  logic hs_rise, vs_rise, ack_rise;
  hdmi_out_pkg::pixel_t exp_pix;

  assign err_cnt_o = err_cnt;
  assign hs_rise   = hsync_i && !hs_q;
  assign vs_rise   = vsync_i && !vs_q;
  assign ack_rise  = mode_ack_i && !ack_q;

  // R from bit 2, G from bit 1, B from bit 0
  function automatic hdmi_out_pkg::pixel_t bar_colour(int idx);
    logic [2:0] bar;
    bar = 3'(idx);
    return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
  endfunction

  task automatic report_value(input string what, input int exp_v, input int act_v);
    err_cnt++;
    $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", what, exp_v, act_v);
  endtask

  task automatic report_event(input string what);
    err_cnt++;
    $display("Check error: %s", what);
  endtask

  // Bar index is the burst position over the bar width
  assign exp_pix = de_i ? bar_colour(de_len / (hdmi_out_pkg::H_ACTIVE[mode_m] / 8))
                        : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_q      <= 1'b0;
      vs_q      <= 1'b0;
      de_q      <= 1'b0;
      req_q     <= 1'b0;
      ack_q     <= 1'b0;
      h_per     <= 0;
      hs_len    <= 0;
      vs_len    <= 0;
      de_len    <= 0;
      de_idle   <= 0;
      hs_cnt    <= 0;
      burst_cnt <= 0;
      seen_de   <= 1'b0;
      chg_win   <= 1'b0;
      mode_m    <= 1'b0;
      mode_new  <= 1'b0;
    end else begin
      hs_q    <= hsync_i;
      vs_q    <= vsync_i;
      de_q    <= de_i;
      req_q   <= mode_req_i;
      ack_q   <= mode_ack_i;
      h_per   <= hs_rise ? 1 : h_per + 1;
      hs_len  <= hsync_i ? hs_len + 1 : 0;
      vs_len  <= vsync_i ? vs_len + 1 : 0;
      de_len  <= de_i ? de_len + 1 : 0;
      de_idle <= de_i ? 0 : de_idle + 1;
      if (hs_rise)
        hs_cnt <= hs_cnt + 1;
      // Bursts counted from one vsync to the next
      if (vs_rise)
        burst_cnt <= 0;
      else if (de_q && !de_i)
        burst_cnt <= burst_cnt + 1;
      if (de_i)
        seen_de <= 1'b1;
      // Change window runs from req rise to ack rise
      if (mode_req_i && !req_q) begin
        chg_win  <= 1'b1;
        mode_new <= mode_sel_i;
      end
      if (ack_rise) begin
        chg_win <= 1'b0;
        mode_m  <= mode_new;
      end
    end
  end

  ////////////////////////////////////////
  // Assertions on the pins
  ////////////////////////////////////////

  // First frame after reset fully blanked
  a_reset_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hs_cnt < hdmi_out_pkg::V_TOTAL[0]) |-> !de_i && (vd_i == '0) && !mode_ack_i)
    else report_value("mode_ack_o,de_o,vd_o", 0,
                      int'({$sampled(mode_ack_i), $sampled(de_i), $sampled(vd_i)}));

  a_de_appears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hs_rise && (hs_cnt == hdmi_out_pkg::V_TOTAL[0]) |-> seen_de)
    else report_event("de_o did not appear after the first frame");

  // Old or new mode allowed while a change runs
  a_line_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hs_rise && (hs_cnt > 0) |-> (h_per == hdmi_out_pkg::H_TOTAL[mode_m])
      || (chg_win && (h_per == hdmi_out_pkg::H_TOTAL[mode_new])))
    else report_value("hsync_o period", hdmi_out_pkg::H_TOTAL[$sampled(mode_m)],
                      $sampled(h_per));

  a_hsync_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hs_q && !hsync_i |-> (hs_len == hdmi_out_pkg::H_SYNC_LEN[mode_m])
      || (chg_win && (hs_len == hdmi_out_pkg::H_SYNC_LEN[mode_new])))
    else report_value("hsync_o width", hdmi_out_pkg::H_SYNC_LEN[$sampled(mode_m)],
                      $sampled(hs_len));

  // Vsync width in cycles, whole lines
  a_vsync_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vs_q && !vsync_i |->
      (vs_len == hdmi_out_pkg::V_SYNC_LEN[mode_m] * hdmi_out_pkg::H_TOTAL[mode_m])
      || (chg_win && (vs_len == hdmi_out_pkg::V_SYNC_LEN[mode_new]
                                * hdmi_out_pkg::H_TOTAL[mode_new])))
    else report_value("vsync_o width", hdmi_out_pkg::V_SYNC_LEN[$sampled(mode_m)]
                      * hdmi_out_pkg::H_TOTAL[$sampled(mode_m)], $sampled(vs_len));

  a_de_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    de_q && !de_i |-> de_len == hdmi_out_pkg::H_ACTIVE[mode_m])
    else report_value("de_o burst", hdmi_out_pkg::H_ACTIVE[$sampled(mode_m)],
                      $sampled(de_len));

  // Empty frames only while blanked
  a_bursts: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vs_rise |-> (burst_cnt == hdmi_out_pkg::V_ACTIVE[mode_m])
      || ((burst_cnt == 0) && (chg_win || !seen_de)))
    else report_value("de_o bursts per frame", hdmi_out_pkg::V_ACTIVE[$sampled(mode_m)],
                      $sampled(burst_cnt));

  a_pixel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vd_i == exp_pix)
    else report_value("vd_o", int'($sampled(exp_pix)), int'($sampled(vd_i)));

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  a_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_rise |-> mode_req_i)
    else report_event("mode_ack_o rose while mode_req_i was low");

  // Whole blanked frame of the new mode before ack
  a_ack_blank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_rise |-> de_idle >= hdmi_out_pkg::H_TOTAL[mode_new]
                            * hdmi_out_pkg::V_TOTAL[mode_new])
    else report_event($sformatf("de_o low for only %0d cycles before mode_ack_o",
                                $sampled(de_idle)));

  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_q && !mode_ack_i |-> !req_q)
    else report_event("mode_ack_o fell before mode_req_i fell");

  a_ack_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_q && !req_q |-> !mode_ack_i)
    else report_value("mode_ack_o", 0, int'($sampled(mode_ack_i)));

endmodule

// File: verification/tb_clk_gen.sv
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low for the first cycles
  initial begin
    rst_n_o <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: src/hdmi_out_top.sv
////////////////////////////////////////
// HDMI output stage top level
// Sequencer, raster counter, bar source
// and output registers
////////////////////////////////////////

`timescale 1ns/100ps

module hdmi_out_top #(
  parameter int COLOR_WIDTH_O = 8
) (
  input  logic                 HDMI_CLK_w,
  input  logic                 HDMI_nRST_pp_w,
  // Mode change handshake
  input  logic                 mode_req_i,
  input  hdmi_out_pkg::mode_t  mode_sel_i,
  output logic                 mode_ack_o,
  // Transmitter RGB bus
  output logic                 vsync_o,
  output logic                 hsync_o,
  output logic                 de_o,
  output hdmi_out_pkg::pixel_t vd_o
);

  hdmi_out_pkg::mode_t  active_mode_w;
  hdmi_out_pkg::pixel_t pixel_w;
  logic restart_w;
  logic blank_w;

  vid_timing_if tim_if ();

  hdmi_mode_fsm u_mode_fsm (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_pp_w(HDMI_nRST_pp_w),
    .mode_req_i    (mode_req_i),
    .mode_sel_i    (mode_sel_i),
    .mode_ack_o    (mode_ack_o),
    .tim           (tim_if),
    .active_mode_o (active_mode_w),
    .restart_o     (restart_w),
    .blank_o       (blank_w)
  );

  video_timing_gen u_timing (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_pp_w(HDMI_nRST_pp_w),
    .mode_i        (active_mode_w),
    .restart_i     (restart_w),
    .tim           (tim_if)
  );

  color_bar_gen #(
    .COLOR_WIDTH_O(COLOR_WIDTH_O)
  ) u_bars (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_pp_w(HDMI_nRST_pp_w),
    .tim           (tim_if),
    .mode_i        (active_mode_w),
    .pixel_o       (pixel_w)
  );

  video_out_regs #(
    .COLOR_WIDTH_O(COLOR_WIDTH_O)
  ) u_out_regs (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_pp_w(HDMI_nRST_pp_w),
    .tim           (tim_if),
    .pixel_i       (pixel_w),
    .blank_i       (blank_w),
    .vsync_o       (vsync_o),
    .hsync_o       (hsync_o),
    .de_o          (de_o),
    .vd_o          (vd_o)
  );

endmodule

// File: src/video_out_regs.sv
////////////////////////////////////////
// Output register stage
// Aligns syncs to the pixel, blanks and
// drives the transmitter pins
////////////////////////////////////////

`timescale 1ns/100ps

module video_out_regs #(
  parameter int COLOR_WIDTH_O = 8
) (
  input  logic                 HDMI_CLK_w,
  input  logic                 HDMI_nRST_pp_w,
  vid_timing_if.sink           tim,
  input  hdmi_out_pkg::pixel_t pixel_i,
  input  logic                 blank_i,
  output logic                 vsync_o,
  output logic                 hsync_o,
  output logic                 de_o,
  output hdmi_out_pkg::pixel_t vd_o
);

  // Stage 1, matches the pixel register
  logic hs_d, vs_d, de_d;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_pp_w) begin
    if (!HDMI_nRST_pp_w) begin
      hs_d <= 1'b0;
      vs_d <= 1'b0;
      de_d <= 1'b0;
    end else begin
      hs_d <= tim.hsync;
      vs_d <= tim.vsync;
      de_d <= tim.de;
    end
  end

  ////////////////////////////////////////
  // Stage 2, fast output registers
  ////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_pp_w) begin
    if (!HDMI_nRST_pp_w) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vd_o    <= {3*COLOR_WIDTH_O{1'b0}};
    end else begin
      // Syncs keep running while blanked
      hsync_o <= hs_d;
      vsync_o <= vs_d;
      de_o    <= de_d & ~blank_i;
      vd_o    <= blank_i ? {3*COLOR_WIDTH_O{1'b0}} : pixel_i;
    end
  end

  // Source zeroes pixels outside de
  a_vd_idle: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_pp_w)
    !de_o |-> vd_o == '0)
    else $error("vd_o not zero outside de_o");

endmodule

// File: src/color_bar_gen.sv
////////////////////////////////////////
// Colour-bar pixel source
// Eight bars per line, one register
////////////////////////////////////////

`timescale 1ns/100ps

module color_bar_gen #(
  parameter int COLOR_WIDTH_O = 8
) (
  input  logic                 HDMI_CLK_w,
  input  logic                 HDMI_nRST_pp_w,
  vid_timing_if.sink           tim,
  input  hdmi_out_pkg::mode_t  mode_i,
  output hdmi_out_pkg::pixel_t pixel_o
);

  logic [2:0] bar_r, bar_cur;
  // Pixel within bar, bar width up to 6
  logic [2:0] pib_r, pib_cur;
  logic [2:0] pib_last;

  assign pib_last = 3'(hdmi_out_pkg::H_ACTIVE[mode_i] / 8 - 1);
  // Line start restarts both counters
  assign bar_cur  = tim.line_start ? 3'd0 : bar_r;
  assign pib_cur  = tim.line_start ? 3'd0 : pib_r;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_pp_w) begin
    if (!HDMI_nRST_pp_w) begin
      bar_r <= 3'd0;
      pib_r <= 3'd0;
    end else if (tim.de && (pib_cur == pib_last)) begin
      bar_r <= bar_cur + 3'd1;
      pib_r <= 3'd0;
    end else if (tim.de) begin
      bar_r <= bar_cur;
      pib_r <= pib_cur + 3'd1;
    end
  end

  // R on bit 2, G on bit 1, B on bit 0
  always_ff @(posedge HDMI_CLK_w) begin
    pixel_o <= tim.de ? {{COLOR_WIDTH_O{bar_cur[2]}}, {COLOR_WIDTH_O{bar_cur[1]}},
                         {COLOR_WIDTH_O{bar_cur[0]}}} : {3*COLOR_WIDTH_O{1'b0}};
  end

  // Last active pixel of a line lands in bar 7
  a_bar_end: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_pp_w)
    tim.de && (tim.hcnt == 7'(hdmi_out_pkg::H_ACTIVE[mode_i] - 1)) |-> bar_cur == 3'd7)
    else $error("bar counter out of step with hcnt");

endmodule

// File: src/video_timing_gen.sv
////////////////////////////////////////
// Raster timing counter
// H/V counters and sync, de and strobe
// decode for the stored mode
////////////////////////////////////////

`timescale 1ns/100ps

module video_timing_gen (
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_pp_w,
  input  hdmi_out_pkg::mode_t mode_i,
  input  logic                restart_i,
  vid_timing_if.gen           tim
);

  hdmi_out_pkg::mode_t mode_r;
  hdmi_out_pkg::hcnt_t hcnt_r, h_last, h_act, hs_beg, hs_end;
  hdmi_out_pkg::vcnt_t vcnt_r, v_last, v_act, vs_beg, vs_end;
  logic line_end;

  // Limits of the stored mode
  always_comb begin
    h_last = hdmi_out_pkg::hcnt_t'(hdmi_out_pkg::H_TOTAL[mode_r] - 1);
    h_act  = hdmi_out_pkg::hcnt_t'(hdmi_out_pkg::H_ACTIVE[mode_r]);
    hs_beg = hdmi_out_pkg::hcnt_t'(hdmi_out_pkg::H_SYNC_START[mode_r]);
    hs_end = hdmi_out_pkg::hcnt_t'(hdmi_out_pkg::H_SYNC_START[mode_r]
                                   + hdmi_out_pkg::H_SYNC_LEN[mode_r]);
    v_last = hdmi_out_pkg::vcnt_t'(hdmi_out_pkg::V_TOTAL[mode_r] - 1);
    v_act  = hdmi_out_pkg::vcnt_t'(hdmi_out_pkg::V_ACTIVE[mode_r]);
    vs_beg = hdmi_out_pkg::vcnt_t'(hdmi_out_pkg::V_SYNC_START[mode_r]);
    vs_end = hdmi_out_pkg::vcnt_t'(hdmi_out_pkg::V_SYNC_START[mode_r]
                                   + hdmi_out_pkg::V_SYNC_LEN[mode_r]);
  end

  assign line_end = (hcnt_r == h_last);

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_pp_w) begin
    if (!HDMI_nRST_pp_w) begin
      mode_r <= 1'b0;
      hcnt_r <= '0;
      vcnt_r <= '0;
    end else if (restart_i) begin
      // Load new mode, start a fresh frame
      mode_r <= mode_i;
      hcnt_r <= '0;
      vcnt_r <= '0;
    end else if (line_end) begin
      hcnt_r <= '0;
      vcnt_r <= (vcnt_r == v_last) ? '0 : vcnt_r + 5'd1;
    end else begin
      hcnt_r <= hcnt_r + 7'd1;
    end
  end

  // Decode, active high syncs
  assign tim.hcnt       = hcnt_r;
  assign tim.vcnt       = vcnt_r;
  assign tim.hsync      = (hcnt_r >= hs_beg) && (hcnt_r < hs_end);
  assign tim.vsync      = (vcnt_r >= vs_beg) && (vcnt_r < vs_end);
  assign tim.de         = (hcnt_r < h_act) && (vcnt_r < v_act);
  assign tim.line_start = (hcnt_r == '0);
  assign tim.frame_end  = line_end && (vcnt_r == v_last);

  a_cnt_range: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_pp_w)
    (hcnt_r <= h_last) && (vcnt_r <= v_last))
    else $error("raster count beyond total");

endmodule

// File: src/hdmi_mode_fsm.sv
////////////////////////////////////////
// Mode sequencer
// Serves the req/ack mode change and
// blanks the picture while it settles
////////////////////////////////////////

`timescale 1ns/100ps

module hdmi_mode_fsm (
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_pp_w,
  input  logic                mode_req_i,
  input  hdmi_out_pkg::mode_t mode_sel_i,
  output logic                mode_ack_o,
  vid_timing_if.ctrl          tim,
  output hdmi_out_pkg::mode_t active_mode_o,
  output logic                restart_o,
  output logic                blank_o
);

  hdmi_out_pkg::fsm_state_t state_r, state_nxt;
  // Requested mode, latched on accept
  hdmi_out_pkg::mode_t req_mode_r;
  // Mode the raster is running in
  hdmi_out_pkg::mode_t cur_mode_r;
  // Set by a restart, so SETTLE ends in ACKED
  logic chg_pend_r;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      hdmi_out_pkg::SETTLE:
        if (tim.frame_end)
          state_nxt = chg_pend_r ? hdmi_out_pkg::ACKED : hdmi_out_pkg::RUN;
      hdmi_out_pkg::RUN:
        if (mode_req_i)
          state_nxt = hdmi_out_pkg::DRAIN;
      hdmi_out_pkg::DRAIN:
        if (tim.frame_end)
          state_nxt = hdmi_out_pkg::SETTLE;
      hdmi_out_pkg::ACKED:
        if (!mode_req_i)
          state_nxt = hdmi_out_pkg::RUN;
      default:
        state_nxt = hdmi_out_pkg::SETTLE;
    endcase
  end

  // Restart on the last pixel of the drained frame
  assign restart_o     = (state_r == hdmi_out_pkg::DRAIN) && tim.frame_end;
  // New mode presented together with restart
  assign active_mode_o = restart_o ? req_mode_r : cur_mode_r;
  assign blank_o       = (state_r == hdmi_out_pkg::SETTLE);
  assign mode_ack_o    = (state_r == hdmi_out_pkg::ACKED);

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_pp_w) begin
    if (!HDMI_nRST_pp_w) begin
      state_r    <= hdmi_out_pkg::SETTLE;
      req_mode_r <= 1'b0;
      cur_mode_r <= 1'b0;
      chg_pend_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      if ((state_r == hdmi_out_pkg::RUN) && mode_req_i)
        req_mode_r <= mode_sel_i;
      if (restart_o) begin
        cur_mode_r <= req_mode_r;
        chg_pend_r <= 1'b1;
      end else if ((state_r == hdmi_out_pkg::SETTLE) && tim.frame_end) begin
        chg_pend_r <= 1'b0;
      end
    end
  end

  // Requester keeps the mode steady for the whole request
  a_sel_stable: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_pp_w)
    mode_req_i |=> !mode_req_i || $stable(mode_sel_i))
    else $error("mode_sel_i changed while mode_req_i was high");

  // Ack only answers a live request
  a_ack_rise: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_pp_w)
    $rose(mode_ack_o) |-> mode_req_i)
    else $error("mode_ack_o rose without mode_req_i");

endmodule

// File: src/vid_timing_if.sv
////////////////////////////////////////
// Raster bus from the timing counter
// to the sequencer and the data path
////////////////////////////////////////

`timescale 1ns/100ps

interface vid_timing_if;
  hdmi_out_pkg::hcnt_t hcnt;
  hdmi_out_pkg::vcnt_t vcnt;
  logic hsync;
  logic vsync;
  logic de;
  // One-cycle strobes
  logic line_start;
  logic frame_end;

  modport gen  (output hcnt, vcnt, hsync, vsync, de, line_start, frame_end);
  modport sink (input hcnt, vcnt, hsync, vsync, de, line_start);
  modport ctrl (input frame_end);
endinterface

// File: src/hdmi_out_pkg.sv
////////////////////////////////////////
// HDMI output stage shared definitions
// Pixel, raster and mode types, FSM
// states and the per-mode raster tables
////////////////////////////////////////

package hdmi_out_pkg;

  // Channel and pixel, R in the top byte
  typedef logic [7:0]  color_t;
  typedef logic [23:0] pixel_t;

  // Raster position
  typedef logic [6:0] hcnt_t;
  typedef logic [4:0] vcnt_t;

  // Output mode select, 0 or 1
  typedef logic mode_t;

  // Mode sequencer states
  typedef enum logic [1:0] {
    SETTLE = 2'd0,
    RUN    = 2'd1,
    DRAIN  = 2'd2,
    ACKED  = 2'd3
  } fsm_state_t;

  ////////////////////////////////////////
  // Raster tables, indexed by mode
  ////////////////////////////////////////

  // Short stand-ins for 480p and 720p
  localparam int H_TOTAL      [2] = '{40, 56};
  localparam int H_ACTIVE     [2] = '{32, 48};
  localparam int H_SYNC_START [2] = '{34, 50};
  localparam int H_SYNC_LEN   [2] = '{3, 4};
  localparam int V_TOTAL      [2] = '{12, 16};
  localparam int V_ACTIVE     [2] = '{8, 12};
  localparam int V_SYNC_START [2] = '{9, 13};
  localparam int V_SYNC_LEN   [2] = '{2, 2};

endpackage
